// ==== Bender.yml ====
package:
  name: serv_bitserial

sources:
  - files:
      - src/serv_pkg.sv
      - src/serv_state.sv
      - src/serv_decode.sv
      - src/serv_immdec.sv
      - src/serv_alu.sv
      - src/serv_ctrl.sv
      - src/serv_rf.sv
      - src/serv_trace.sv
      - src/serv_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_serv.sv

// ==== sim/tb_serv_model.svh ====
`ifndef TB_SERV_MODEL_SVH
`define TB_SERV_MODEL_SVH

// Architectural state of the reference model
logic [31:0] model_regs [32];
logic [31:0] model_pc  = 32'h0;
int          gen_count = 0;

initial begin
   foreach (model_regs[i]) begin
      model_regs[i] = '0;
   end
end

function automatic int unsigned rand_below(input int unsigned n);
   return $unsigned($random(seed)) % n;
endfunction

function automatic logic [31:0] gen_instr();
   logic [31:0] r;
   logic [4:0]  rd;
   logic [4:0]  rs1;
   logic [4:0]  rs2;
   logic [2:0]  f3;
   logic [20:0] off;
   int unsigned kind;
   r    = $random(seed);
   rd   = 5'(rand_below(8));
   rs1  = 5'(rand_below(8));
   rs2  = 5'(rand_below(8));
   f3   = 3'(rand_below(8));
   // Shift encodings move to the next ALU op
   if ((f3 == 3'b001) || (f3 == 3'b101)) begin
      f3 = f3 + 3'd1;
   end
   kind = rand_below(16);
   gen_count++;
   // x1..x7 get a value first
   if (gen_count <= 7) begin
      return {r[11:0], 5'd0, 3'b000, 5'(gen_count), serv_pkg::OPC_OP_IMM};
   end
   if (kind < 4) begin
      return {((f3 == 3'b000) && r[30]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, serv_pkg::OPC_OP};
   end
   if (kind < 7) begin
      return {r[31:20], rs1, f3, rd, serv_pkg::OPC_OP_IMM};
   end
   if (kind < 9) begin
      return {r[31:12], rd, serv_pkg::OPC_LUI};
   end
   if (kind < 10) begin
      off = 21'((int'(rand_below(17)) - 8) * 4);
      return {off[20], off[10:1], off[11], off[19:12], rd, serv_pkg::OPC_JAL};
   end
   if (kind < 13) begin
      // BEQ, BNE, BLT or BGE
      off = 21'((int'(rand_below(9)) - 4) * 4);
      return {off[12], off[10:5], rs2, rs1, r[2], 1'b0, r[0], off[4:1], off[11],
              serv_pkg::OPC_BRANCH};
   end
   case (rand_below(5))
      0:       return {r[31:7], 7'b0000011};
      1:       return {r[31:7], 7'b1100111};
      2:       return {r[31:15], r[12] ? 3'b001 : 3'b101, rd, serv_pkg::OPC_OP_IMM};
      3:       return {7'h01, r[24:7], serv_pkg::OPC_OP};
      default: return {r[31:15], r[13], 1'b1, r[12], r[11:7], serv_pkg::OPC_BRANCH};
   endcase
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
   case (f3)
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b110:  return a | b;
      3'b111:  return a & b;
      default: return a + b;
   endcase
endfunction

function automatic void ref_execute(input logic [31:0] instr, output logic [4:0] exp_rd,
                                    output logic [31:0] exp_wdata);
   logic [2:0]  f3;
   logic [6:0]  f7;
   logic [4:0]  rd;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm_i;
   logic [31:0] result;
   logic [31:0] next_pc;
   logic        writes;
   logic        taken;
   f3      = instr[14:12];
   f7      = instr[31:25];
   rd      = instr[11:7];
   a       = model_regs[instr[19:15]];
   b       = model_regs[instr[24:20]];
   imm_i   = {{20{instr[31]}}, instr[31:20]};
   result  = '0;
   writes  = 1'b0;
   taken   = 1'b0;
   next_pc = model_pc + 32'd4;
   case (instr[6:0])
      serv_pkg::OPC_OP: begin
         if ((f7 == 7'h00) && (f3 != 3'b001) && (f3 != 3'b101)) begin
            result = alu_ref(f3, a, b);
            writes = 1'b1;
         end else if ((f7 == 7'h20) && (f3 == 3'b000)) begin
            result = a - b;
            writes = 1'b1;
         end
      end
      serv_pkg::OPC_OP_IMM: begin
         if ((f3 != 3'b001) && (f3 != 3'b101)) begin
            result = alu_ref(f3, a, imm_i);
            writes = 1'b1;
         end
      end
      serv_pkg::OPC_LUI: begin
         result = {instr[31:12], 12'h000};
         writes = 1'b1;
      end
      serv_pkg::OPC_JAL: begin
         result  = model_pc + 32'd4;
         writes  = 1'b1;
         next_pc = model_pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      serv_pkg::OPC_BRANCH: begin
         case (f3)
            3'b000:  taken = (a == b);
            3'b001:  taken = (a != b);
            3'b100:  taken = ($signed(a) < $signed(b));
            3'b101:  taken = ($signed(a) >= $signed(b));
            default: taken = 1'b0;
         endcase
         if (taken) begin
            next_pc = model_pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         end
      end
      default: ;
   endcase
   if (writes && (rd != 5'd0)) begin
      model_regs[rd] = result;
      exp_rd         = rd;
      exp_wdata      = result;
   end else begin
      exp_rd    = '0;
      exp_wdata = '0;
   end
   model_pc = next_pc;
endfunction

`endif

// ==== sim/tb_serv.sv ====
`timescale 1ns/1ps

module tb_serv;

   localparam int CLK_PERIOD    = 4;
   localparam int RESET_CYCLES  = 4;
   localparam int N_INSTR       = 400;
   localparam int MAX_WAIT      = 7;
   localparam int BRANCH_CYCLES = 66;
   // Longest bus wait plus a branch plus the handshake for each instruction
   localparam int WATCHDOG_NS   =
      (N_INSTR * (MAX_WAIT + BRANCH_CYCLES + 2) + RESET_CYCLES) * CLK_PERIOD;

   logic                          clk;
   logic                          arst_n;
   logic [serv_pkg::XLEN-1:0]     ibus_rdt;
   logic                          ibus_ack;
   logic [serv_pkg::XLEN-1:0]     ibus_adr;
   logic                          ibus_cyc;
   logic                          retire;
   logic [serv_pkg::XLEN-1:0]     retire_pc;
   logic [serv_pkg::REG_AW-1:0]   retire_rd;
   logic [serv_pkg::XLEN-1:0]     retire_wdata;

   integer      seed = 32'h5c13;
   logic [31:0] fetch_instr_q [$];
   logic [31:0] fetch_adr_q [$];

   `include "tb_serv_model.svh"

   serv_top #(
      .RESET_PC (32'h0)
   ) serv_top_inst (
      .clk            (clk),
      .i_arst_n       (arst_n),
      .i_ibus_rdt     (ibus_rdt),
      .i_ibus_ack     (ibus_ack),
      .o_ibus_adr     (ibus_adr),
      .o_ibus_cyc     (ibus_cyc),
      .o_retire       (retire),
      .o_retire_pc    (retire_pc),
      .o_retire_rd    (retire_rd),
      .o_retire_wdata (retire_wdata)
   );

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string test_name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         fail_run($sformatf("mismatch %s: expected %08h, actual %08h",
                            test_name, expected, actual));
      end
   endtask

   always #(CLK_PERIOD / 2) clk = ~clk;

   initial begin
      clk      = 1'b0;
      arst_n   = 1'b0;
      ibus_ack = 1'b0;
      ibus_rdt = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

   // Answers each fetch after a random number of wait states
   initial begin : bus_responder
      int unsigned wait_cycles;
      logic [31:0] word;
      logic [31:0] req_adr;
      wait (arst_n === 1'b1);
      forever begin
         @(negedge clk);
         if (ibus_cyc === 1'b1) begin
            req_adr     = ibus_adr;
            wait_cycles = rand_below(MAX_WAIT + 1);
            repeat (wait_cycles) begin
               @(negedge clk);
               if (ibus_cyc !== 1'b1) begin
                  fail_run("core withdrew its fetch request before the acknowledge");
               end
               if (ibus_adr !== req_adr) begin
                  fail_run("fetch address changed while the request was pending");
               end
            end
            word = gen_instr();
            fetch_instr_q.push_back(word);
            fetch_adr_q.push_back(req_adr);
            ibus_rdt = word;
            ibus_ack = 1'b1;
            @(negedge clk);
            ibus_ack = 1'b0;
            ibus_rdt = '0;
            if (ibus_cyc !== 1'b0) begin
               fail_run("core kept its fetch request up after the acknowledge");
            end
         end
      end
   end

   initial begin : compare_retire
      logic [31:0] instr;
      logic [31:0] adr;
      logic [4:0]  exp_rd;
      logic [31:0] exp_wdata;
      int          retired;
      string       tag;
      retired = 0;
      wait (arst_n === 1'b1);
      while (retired < N_INSTR) begin
         @(negedge clk);
         if (retire === 1'b1) begin
            if (fetch_instr_q.size() == 0) begin
               fail_run("core retired an instruction that was never fetched");
            end
            instr = fetch_instr_q.pop_front();
            adr   = fetch_adr_q.pop_front();
            tag   = $sformatf("instr %0d (%08h)", retired, instr);
            check_value({tag, " fetch address"}, model_pc, adr);
            check_value({tag, " retire pc"}, model_pc, retire_pc);
            ref_execute(instr, exp_rd, exp_wdata);
            check_value({tag, " retire rd"}, 32'(exp_rd), 32'(retire_rd));
            check_value({tag, " retire wdata"}, exp_wdata, retire_wdata);
            retired++;
         end
      end
      $display("No errors");
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      fail_run($sformatf("timeout: core stopped retiring within %0d ns", WATCHDOG_NS));
   end

endmodule

// ==== src/serv_alu.sv ====
`timescale 1ns/1ps

module serv_alu (
   input  logic                clk,
   input  logic                i_init,
   input  logic                i_cnt_en,
   input  logic                i_cnt_done,
   input  serv_pkg::alu_op_e   i_alu_op,
   input  logic                i_rs1_bit,
   input  logic                i_op_b_bit,
   output logic                o_alu_bit,
   output logic                o_cmp
);

   logic sub_type;
   logic b_bit;
   logic sum;
   logic carry;
   logic carry_out;
   logic bit_eq;
   logic eq;
   logic first_bit;
   logic lt_s;
   logic lt_u;

   assign sub_type = (i_alu_op == serv_pkg::ALU_SUB) || (i_alu_op == serv_pkg::ALU_SLT) ||
                     (i_alu_op == serv_pkg::ALU_SLTU);
   assign b_bit     = i_op_b_bit ^ sub_type;
   assign sum       = i_rs1_bit ^ b_bit ^ carry;
   assign carry_out = (i_rs1_bit & b_bit) | (carry & (i_rs1_bit ^ b_bit));
   assign bit_eq    = !(i_rs1_bit ^ i_op_b_bit);

   // Valid at the MSB only
   assign lt_u = !carry_out;
   assign lt_s = (i_rs1_bit ^ i_op_b_bit) ? i_rs1_bit : sum;

   always_ff @(posedge clk) begin
      if (i_init || i_cnt_done) begin
         carry     <= sub_type;
         eq        <= 1'b1;
         first_bit <= 1'b1;
      end else if (i_cnt_en) begin
         carry     <= carry_out;
         eq        <= eq & bit_eq;
         first_bit <= 1'b0;
      end
      if (i_cnt_done) begin
         case (i_alu_op)
            serv_pkg::ALU_SLT:  o_cmp <= lt_s;
            serv_pkg::ALU_SLTU: o_cmp <= lt_u;
            default:            o_cmp <= eq & bit_eq;
         endcase
      end
   end

   always_comb begin
      case (i_alu_op)
         serv_pkg::ALU_AND: o_alu_bit = i_rs1_bit & i_op_b_bit;
         serv_pkg::ALU_OR:  o_alu_bit = i_rs1_bit | i_op_b_bit;
         serv_pkg::ALU_XOR: o_alu_bit = i_rs1_bit ^ i_op_b_bit;
         serv_pkg::ALU_SLT,
         serv_pkg::ALU_SLTU: o_alu_bit = first_bit & o_cmp;
         default:           o_alu_bit = sum;
      endcase
   end

endmodule

// ==== src/serv_ctrl.sv ====
`timescale 1ns/1ps

module serv_ctrl #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                         clk,
   input  logic                         i_arst_n,
   input  logic                         i_cnt_en,
   input  logic [serv_pkg::CNT_W-1:0]   i_cnt,
   input  logic                         i_final_pass,
   input  logic                         i_jump,
   input  logic                         i_imm_bit,
   output logic [serv_pkg::XLEN-1:0]    o_ibus_adr,
   output logic                         o_link_bit
);

   logic first;
   logic c4;
   logic c4_in;
   logic c4_out;
   logic ci;
   logic ci_in;
   logic ci_out;
   logic s_imm;
   logic plus4_in;
   logic new_bit;

   assign first    = (i_cnt == '0);
   assign plus4_in = (i_cnt == serv_pkg::CNT_W'(2));

   // PC+4
   assign c4_in      = first ? 1'b0 : c4;
   assign o_link_bit = o_ibus_adr[0] ^ plus4_in ^ c4_in;
   assign c4_out     = (o_ibus_adr[0] & plus4_in) | (c4_in & (o_ibus_adr[0] ^ plus4_in));

   // PC+imm
   assign ci_in  = first ? 1'b0 : ci;
   assign s_imm  = o_ibus_adr[0] ^ i_imm_bit ^ ci_in;
   assign ci_out = (o_ibus_adr[0] & i_imm_bit) | (ci_in & (o_ibus_adr[0] ^ i_imm_bit));

   assign new_bit = i_jump ? s_imm : o_link_bit;

   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         c4 <= c4_out;
         ci <= ci_out;
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_ibus_adr <= RESET_PC;
      end else if (i_cnt_en && i_final_pass) begin
         o_ibus_adr <= {new_bit, o_ibus_adr[serv_pkg::XLEN-1:1]};
      end
   end

   // Whole PC is back in place whenever no pass runs
   a_pc_aligned : assert property (
      @(posedge clk) disable iff (!i_arst_n) !i_cnt_en |-> (o_ibus_adr[1:0] == 2'b00));

endmodule

// ==== src/serv_decode.sv ====
`timescale 1ns/1ps

module serv_decode (
   input  logic                        clk,
   input  logic                        i_arst_n,
   input  logic                        i_ibus_ack,
   input  logic [serv_pkg::XLEN-1:0]   i_instr,
   output serv_pkg::op_class_e         o_op_class,
   output serv_pkg::alu_op_e           o_alu_op,
   output logic                        o_op_b_imm,
   output logic                        o_br_invert,
   output logic                        o_two_pass
);

   logic [6:0]          opcode;
   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic                f3_ok;
   serv_pkg::alu_op_e   f3_op;
   serv_pkg::op_class_e cls;
   serv_pkg::alu_op_e   op;
   logic                invert;
   logic                is_slt;

   assign opcode = i_instr[6:0];
   assign funct3 = i_instr[14:12];
   assign funct7 = i_instr[31:25];

   // Shifts have no place in this core
   assign f3_ok = (funct3 != 3'b001) && (funct3 != 3'b101);

   always_comb begin
      case (funct3)
         3'b010:  f3_op = serv_pkg::ALU_SLT;
         3'b011:  f3_op = serv_pkg::ALU_SLTU;
         3'b100:  f3_op = serv_pkg::ALU_XOR;
         3'b110:  f3_op = serv_pkg::ALU_OR;
         3'b111:  f3_op = serv_pkg::ALU_AND;
         default: f3_op = serv_pkg::ALU_ADD;
      endcase
   end

   always_comb begin
      cls    = serv_pkg::CLS_NOP;
      op     = serv_pkg::ALU_ADD;
      invert = 1'b0;
      case (opcode)
         serv_pkg::OPC_OP: begin
            if (f3_ok && ((funct7 == 7'h00) || ((funct7 == 7'h20) && (funct3 == 3'b000)))) begin
               cls = serv_pkg::CLS_OP;
               op  = funct7[5] ? serv_pkg::ALU_SUB : f3_op;
            end
         end
         serv_pkg::OPC_OP_IMM: begin
            if (f3_ok) begin
               cls = serv_pkg::CLS_OP_IMM;
               op  = f3_op;
            end
         end
         serv_pkg::OPC_LUI: cls = serv_pkg::CLS_LUI;
         serv_pkg::OPC_JAL: cls = serv_pkg::CLS_JAL;
         serv_pkg::OPC_BRANCH: begin
            // BEQ/BNE compare for equality, BLT/BGE signed
            if ((funct3[2:1] == 2'b00) || (funct3[2:1] == 2'b10)) begin
               cls    = serv_pkg::CLS_BRANCH;
               op     = funct3[2] ? serv_pkg::ALU_SLT : serv_pkg::ALU_SUB;
               invert = funct3[0];
            end
         end
         default: cls = serv_pkg::CLS_NOP;
      endcase
   end

   // SLT needs the full compare before bit 0 can be written
   assign is_slt = ((cls == serv_pkg::CLS_OP) || (cls == serv_pkg::CLS_OP_IMM)) &&
                   ((op == serv_pkg::ALU_SLT) || (op == serv_pkg::ALU_SLTU));

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_op_class  <= serv_pkg::CLS_NOP;
         o_alu_op    <= serv_pkg::ALU_ADD;
         o_op_b_imm  <= 1'b0;
         o_br_invert <= 1'b0;
         o_two_pass  <= 1'b0;
      end else if (i_ibus_ack) begin
         o_op_class  <= cls;
         o_alu_op    <= op;
         o_op_b_imm  <= (cls == serv_pkg::CLS_OP_IMM);
         o_br_invert <= invert;
         o_two_pass  <= (cls == serv_pkg::CLS_BRANCH) || is_slt;
      end
   end

endmodule

// ==== src/serv_immdec.sv ====
`timescale 1ns/1ps

module serv_immdec (
   input  logic                          clk,
   input  logic                          i_ibus_ack,
   input  logic [serv_pkg::XLEN-1:0]     i_instr,
   input  serv_pkg::op_class_e           i_op_class,
   input  logic                          i_cnt_en,
   output logic [serv_pkg::REG_AW-1:0]   o_rd_addr,
   output logic [serv_pkg::REG_AW-1:0]   o_rs1_addr,
   output logic [serv_pkg::REG_AW-1:0]   o_rs2_addr,
   output logic                          o_imm_bit
);

   logic [serv_pkg::XLEN-1:7] instr_q;
   logic [serv_pkg::XLEN-1:0] imm;
   logic [serv_pkg::XLEN-1:0] imm_sr;

   assign o_rd_addr  = instr_q[11:7];
   assign o_rs1_addr = instr_q[19:15];
   assign o_rs2_addr = instr_q[24:20];
   assign o_imm_bit  = imm_sr[0];

   always_comb begin
      case (i_op_class)
         serv_pkg::CLS_OP_IMM: imm = {{20{instr_q[31]}}, instr_q[31:20]};
         serv_pkg::CLS_LUI:    imm = {instr_q[31:12], 12'b0};
         serv_pkg::CLS_JAL:    imm = {{12{instr_q[31]}}, instr_q[19:12], instr_q[20],
                                      instr_q[30:21], 1'b0};
         serv_pkg::CLS_BRANCH: imm = {{20{instr_q[31]}}, instr_q[7], instr_q[30:25],
                                      instr_q[11:8], 1'b0};
         default:              imm = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         instr_q <= i_instr[serv_pkg::XLEN-1:7];
      end
      // Rotate so a second pass sees the same immediate again
      if (i_cnt_en) begin
         imm_sr <= {imm_sr[0], imm_sr[serv_pkg::XLEN-1:1]};
      end else begin
         imm_sr <= imm;
      end
   end

endmodule

// ==== src/serv_pkg.sv ====
package serv_pkg;

   localparam int XLEN   = 32;
   localparam int REG_AW = 5;
   localparam int CNT_W  = 5;

   // RV32I major opcodes, low two bits included
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_JAL    = 7'b1101111;
   localparam logic [6:0] OPC_BRANCH = 7'b1100011;

   typedef enum logic [2:0] {
      CLS_OP,
      CLS_OP_IMM,
      CLS_LUI,
      CLS_JAL,
      CLS_BRANCH,
      CLS_NOP
   } op_class_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_SLTU
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH,
      ST_INIT,
      ST_RUN,
      ST_BRANCH_RUN
   } state_e;

endpackage

// ==== src/serv_rf.sv ====
`timescale 1ns/1ps

module serv_rf (
   input  logic                          clk,
   input  logic [serv_pkg::REG_AW-1:0]   i_rs1_addr,
   input  logic [serv_pkg::REG_AW-1:0]   i_rs2_addr,
   input  logic [serv_pkg::REG_AW-1:0]   i_rd_addr,
   input  logic [serv_pkg::CNT_W-1:0]    i_cnt,
   input  logic                          i_rd_wen,
   input  logic                          i_rd_bit,
   output logic                          o_rs1_bit,
   output logic                          o_rs2_bit
);

   logic [serv_pkg::XLEN-1:0] regs [2**serv_pkg::REG_AW];

   // x0 is never written, so its reads are masked
   assign o_rs1_bit = (i_rs1_addr != '0) && regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = (i_rs2_addr != '0) && regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_rd_wen) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

   a_no_x0_write : assert property (
      @(posedge clk) i_rd_wen |-> (i_rd_addr != '0));

endmodule

// ==== src/serv_state.sv ====
`timescale 1ns/1ps

module serv_state (
   input  logic                        clk,
   input  logic                        i_arst_n,
   input  logic                        i_ibus_ack,
   input  logic                        i_two_pass,
   output logic                        o_ibus_cyc,
   output logic                        o_init,
   output logic                        o_cnt_en,
   output logic [serv_pkg::CNT_W-1:0]  o_cnt,
   output logic                        o_cnt_done,
   output logic                        o_final_pass,
   output logic                        o_retire_stb
);

   serv_pkg::state_e state;

   assign o_ibus_cyc = (state == serv_pkg::ST_FETCH);
   assign o_init     = (state == serv_pkg::ST_INIT);
   assign o_cnt_en   = (state == serv_pkg::ST_RUN) || (state == serv_pkg::ST_BRANCH_RUN);
   assign o_cnt_done = o_cnt_en && (o_cnt == '1);

   // Single pass ops finish in RUN, two pass ops in the second pass
   assign o_final_pass = ((state == serv_pkg::ST_RUN) && !i_two_pass) ||
                         (state == serv_pkg::ST_BRANCH_RUN);

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state        <= serv_pkg::ST_FETCH;
         o_cnt        <= '0;
         o_retire_stb <= 1'b0;
      end else begin
         o_retire_stb <= o_cnt_done && o_final_pass;
         if (o_cnt_en) begin
            o_cnt <= o_cnt + 1'b1;
         end
         case (state)
            serv_pkg::ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= serv_pkg::ST_INIT;
               end
            end
            serv_pkg::ST_INIT: begin
               state <= serv_pkg::ST_RUN;
            end
            serv_pkg::ST_RUN: begin
               if (o_cnt_done) begin
                  state <= i_two_pass ? serv_pkg::ST_BRANCH_RUN : serv_pkg::ST_FETCH;
               end
            end
            serv_pkg::ST_BRANCH_RUN: begin
               if (o_cnt_done) begin
                  state <= serv_pkg::ST_FETCH;
               end
            end
            default: begin
               state <= serv_pkg::ST_FETCH;
            end
         endcase
      end
   end

   // Bus slave must not acknowledge without a pending fetch
   a_ack_in_cyc : assert property (
      @(posedge clk) disable iff (!i_arst_n) i_ibus_ack |-> o_ibus_cyc);

endmodule

// ==== src/serv_top.sv ====
`timescale 1ns/1ps

module serv_top #(
   parameter logic [serv_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  logic [serv_pkg::XLEN-1:0]     i_ibus_rdt,
   input  logic                          i_ibus_ack,
   output logic [serv_pkg::XLEN-1:0]     o_ibus_adr,
   output logic                          o_ibus_cyc,
   output logic                          o_retire,
   output logic [serv_pkg::XLEN-1:0]     o_retire_pc,
   output logic [serv_pkg::REG_AW-1:0]   o_retire_rd,
   output logic [serv_pkg::XLEN-1:0]     o_retire_wdata
);

   logic                        init;
   logic                        cnt_en;
   logic [serv_pkg::CNT_W-1:0]  cnt;
   logic                        cnt_done;
   logic                        final_pass;
   logic                        retire_stb;
   serv_pkg::op_class_e         op_class;
   serv_pkg::alu_op_e           alu_op;
   logic                        op_b_imm;
   logic                        br_invert;
   logic                        two_pass;
   logic [serv_pkg::REG_AW-1:0] rd_addr;
   logic [serv_pkg::REG_AW-1:0] rs1_addr;
   logic [serv_pkg::REG_AW-1:0] rs2_addr;
   logic                        imm_bit;
   logic                        rs1_bit;
   logic                        rs2_bit;
   logic                        op_b_bit;
   logic                        alu_bit;
   logic                        cmp;
   logic                        link_bit;
   logic                        rd_bit;
   logic                        writes_rd;
   logic                        rd_wen;
   logic                        jump;

   assign op_b_bit  = op_b_imm ? imm_bit : rs2_bit;
   assign writes_rd = (op_class == serv_pkg::CLS_OP) || (op_class == serv_pkg::CLS_OP_IMM) ||
                      (op_class == serv_pkg::CLS_LUI) || (op_class == serv_pkg::CLS_JAL);
   // Only SLT has a write in its second pass, all others finish in one
   assign rd_wen    = cnt_en && final_pass && writes_rd && (rd_addr != '0);
   assign jump      = (op_class == serv_pkg::CLS_JAL) ||
                      ((op_class == serv_pkg::CLS_BRANCH) && (cmp ^ br_invert));

   always_comb begin
      case (op_class)
         serv_pkg::CLS_LUI: rd_bit = imm_bit;
         serv_pkg::CLS_JAL: rd_bit = link_bit;
         default:           rd_bit = alu_bit;
      endcase
   end

   serv_state serv_state_inst (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_ibus_ack   (i_ibus_ack),
      .i_two_pass   (two_pass),
      .o_ibus_cyc   (o_ibus_cyc),
      .o_init       (init),
      .o_cnt_en     (cnt_en),
      .o_cnt        (cnt),
      .o_cnt_done   (cnt_done),
      .o_final_pass (final_pass),
      .o_retire_stb (retire_stb)
   );

   serv_decode serv_decode_inst (
      .clk         (clk),
      .i_arst_n    (i_arst_n),
      .i_ibus_ack  (i_ibus_ack),
      .i_instr     (i_ibus_rdt),
      .o_op_class  (op_class),
      .o_alu_op    (alu_op),
      .o_op_b_imm  (op_b_imm),
      .o_br_invert (br_invert),
      .o_two_pass  (two_pass)
   );

   serv_immdec serv_immdec_inst (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_instr    (i_ibus_rdt),
      .i_op_class (op_class),
      .i_cnt_en   (cnt_en),
      .o_rd_addr  (rd_addr),
      .o_rs1_addr (rs1_addr),
      .o_rs2_addr (rs2_addr),
      .o_imm_bit  (imm_bit)
   );

   serv_alu serv_alu_inst (
      .clk        (clk),
      .i_init     (init),
      .i_cnt_en   (cnt_en),
      .i_cnt_done (cnt_done),
      .i_alu_op   (alu_op),
      .i_rs1_bit  (rs1_bit),
      .i_op_b_bit (op_b_bit),
      .o_alu_bit  (alu_bit),
      .o_cmp      (cmp)
   );

   serv_ctrl #(
      .RESET_PC (RESET_PC)
   ) serv_ctrl_inst (
      .clk          (clk),
      .i_arst_n     (i_arst_n),
      .i_cnt_en     (cnt_en),
      .i_cnt        (cnt),
      .i_final_pass (final_pass),
      .i_jump       (jump),
      .i_imm_bit    (imm_bit),
      .o_ibus_adr   (o_ibus_adr),
      .o_link_bit   (link_bit)
   );

   serv_rf serv_rf_inst (
      .clk        (clk),
      .i_rs1_addr (rs1_addr),
      .i_rs2_addr (rs2_addr),
      .i_rd_addr  (rd_addr),
      .i_cnt      (cnt),
      .i_rd_wen   (rd_wen),
      .i_rd_bit   (rd_bit),
      .o_rs1_bit  (rs1_bit),
      .o_rs2_bit  (rs2_bit)
   );

   serv_trace serv_trace_inst (
      .clk            (clk),
      .i_arst_n       (i_arst_n),
      .i_ibus_ack     (i_ibus_ack),
      .i_ibus_adr     (o_ibus_adr),
      .i_rd_wen       (rd_wen),
      .i_rd_addr      (rd_addr),
      .i_rd_bit       (rd_bit),
      .i_retire_stb   (retire_stb),
      .o_retire       (o_retire),
      .o_retire_pc    (o_retire_pc),
      .o_retire_rd    (o_retire_rd),
      .o_retire_wdata (o_retire_wdata)
   );

endmodule

// ==== src/serv_trace.sv ====
`timescale 1ns/1ps

module serv_trace (
   input  logic                          clk,
   input  logic                          i_arst_n,
   input  logic                          i_ibus_ack,
   input  logic [serv_pkg::XLEN-1:0]     i_ibus_adr,
   input  logic                          i_rd_wen,
   input  logic [serv_pkg::REG_AW-1:0]   i_rd_addr,
   input  logic                          i_rd_bit,
   input  logic                          i_retire_stb,
   output logic                          o_retire,
   output logic [serv_pkg::XLEN-1:0]     o_retire_pc,
   output logic [serv_pkg::REG_AW-1:0]   o_retire_rd,
   output logic [serv_pkg::XLEN-1:0]     o_retire_wdata
);

   logic [serv_pkg::XLEN-1:0] wdata_q;
   logic                      wrote;

   assign o_retire       = i_retire_stb;
   assign o_retire_rd    = wrote ? i_rd_addr : '0;
   assign o_retire_wdata = wrote ? wdata_q : '0;

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_retire_pc <= i_ibus_adr;
      end
      // Written bits arrive LSB first
      if (i_rd_wen) begin
         wdata_q <= {i_rd_bit, wdata_q[serv_pkg::XLEN-1:1]};
      end
   end

   always_ff @(posedge clk or negedge i_arst_n) begin
      if (!i_arst_n) begin
         wrote <= 1'b0;
      end else if (i_ibus_ack) begin
         wrote <= 1'b0;
      end else if (i_rd_wen) begin
         wrote <= 1'b1;
      end
   end

endmodule

// ==== tb.f ====
+incdir+sim
src/serv_pkg.sv
src/serv_state.sv
src/serv_decode.sv
src/serv_immdec.sv
src/serv_alu.sv
src/serv_ctrl.sv
src/serv_rf.sv
src/serv_trace.sv
src/serv_top.sv
sim/tb_serv.sv
